/* src/ooo_pkg.sv */
package ooo_pkg;

    // Width of every data value in the core
    parameter int xlen = 32;

    // Architectural register file size and its index type
    parameter int num_regs = 8;
    typedef logic [2:0] reg_idx_t;

    // Station entries carry tags at the widest supported size
    parameter int max_tag_bits = 4;
    typedef logic [max_tag_bits-1:0] tag_max_t;

    // Width of the running dispatch stamp used for age ordering
    parameter int age_bits = 32;

    // ALU operations in the order the front end encodes them
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_sll = 3'd5,
        op_srl = 3'd6,
        op_slt = 3'd7
    } alu_op_e;

    // One renamed instruction waiting in the reservation station
    typedef struct packed {
        alu_op_e               op;
        tag_max_t              dest_tag;
        logic                  src1_ready;
        logic [xlen-1:0]       src1_value;
        tag_max_t              src1_tag;
        logic                  src2_ready;
        logic [xlen-1:0]       src2_value;
        tag_max_t              src2_tag;
        logic [age_bits-1:0]   age;
    } rs_entry_t;

endpackage

/* src/ooo_ifs.sv */
`timescale 1ns/1ps

// Renamed instruction handed from the dispatch glue to the station
interface dispatch_if #(
    parameter int tag_bits = 3
);
    logic                      valid;
    ooo_pkg::alu_op_e          op;
    logic [tag_bits-1:0]       dest_tag;
    logic                      src1_ready;
    logic [tag_bits-1:0]       src1_tag;
    logic [ooo_pkg::xlen-1:0]  src1_value;
    logic                      src2_ready;
    logic [tag_bits-1:0]       src2_tag;
    logic [ooo_pkg::xlen-1:0]  src2_value;

    modport source (output valid, op, dest_tag, src1_ready, src1_tag, src1_value,
                    src2_ready, src2_tag, src2_value);
    modport sink (input valid, op, dest_tag, src1_ready, src1_tag, src1_value,
                  src2_ready, src2_tag, src2_value);
endinterface

// Common data bus carrying one result broadcast per cycle
interface cdb_if #(
    parameter int tag_bits = 3
);
    logic                      valid;
    logic [tag_bits-1:0]       tag;
    logic [ooo_pkg::xlen-1:0]  value;

    modport driver (output valid, tag, value);
    modport listener (input valid, tag, value);
endinterface

/* src/tag_allocator.sv */
`timescale 1ns/1ps

module tag_allocator #(
    parameter int tag_count = 8,
    parameter int tag_bits  = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 alloc,
    cdb_if.listener              cdb,
    output logic [tag_bits-1:0]  alloc_tag,
    output logic                 none_free
);

    localparam int cnt_bits = $clog2(tag_count + 1);

    // One bit per tag and set while the tag is free
    logic [tag_count-1:0] free_map;
    // Number of tags handed out and not yet broadcast
    logic [cnt_bits-1:0]  in_flight;

    // Scan from the top so the lowest free tag wins
    always_comb begin
        alloc_tag = '0;
        for (int i = tag_count - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                alloc_tag = tag_bits'(i);
            end
        end
    end

    assign none_free = (in_flight == cnt_bits'(tag_count));

    // A tag being broadcast is busy so it never equals the allocated one
    always_ff @(posedge clk) begin
        if (rst) begin
            free_map  <= '1;
            in_flight <= '0;
        end else begin
            if (cdb.valid) begin
                free_map[cdb.tag] <= 1'b1;
            end
            if (alloc) begin
                free_map[alloc_tag] <= 1'b0;
            end
            in_flight <= in_flight + cnt_bits'(alloc) - cnt_bits'(cdb.valid);
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        in_flight <= cnt_bits'(tag_count))
        else $error("tag in-flight count exceeds tag_count");

    // The ALU may only broadcast a tag that was handed out earlier
    a_broadcast_busy: assert property (@(posedge clk) disable iff (rst)
        cdb.valid |-> !free_map[cdb.tag])
        else $error("broadcast of free tag %0d", cdb.tag);

endmodule

/* src/register_status.sv */
`timescale 1ns/1ps

module register_status #(
    parameter int tag_bits = 3
) (
    input  logic                      clk,
    input  logic                      rst,
    input  ooo_pkg::reg_idx_t         rs1,
    input  ooo_pkg::reg_idx_t         rs2,
    input  ooo_pkg::reg_idx_t         rd,
    input  logic                      write_tag,
    input  logic [tag_bits-1:0]       new_tag,
    cdb_if.listener                   cdb,
    output logic                      src1_ready,
    output logic [tag_bits-1:0]       src1_tag,
    output logic [ooo_pkg::xlen-1:0]  src1_value,
    output logic                      src2_ready,
    output logic [tag_bits-1:0]       src2_tag,
    output logic [ooo_pkg::xlen-1:0]  src2_value
);

    // Per register state holding the last value and the pending producer
    logic [ooo_pkg::xlen-1:0]     reg_value [ooo_pkg::num_regs];
    logic [ooo_pkg::num_regs-1:0] reg_pending;
    logic [tag_bits-1:0]          reg_tag [ooo_pkg::num_regs];

    typedef struct packed {
        logic                      ready;
        logic [tag_bits-1:0]       tag;
        logic [ooo_pkg::xlen-1:0]  value;
    } read_t;

    // A broadcast of the pending tag in this cycle is forwarded to the reader
    function automatic read_t read_reg(ooo_pkg::reg_idx_t idx);
        read_t r;
        r.ready = !reg_pending[idx];
        r.tag   = reg_tag[idx];
        r.value = reg_value[idx];
        if (reg_pending[idx] && cdb.valid && cdb.tag == reg_tag[idx]) begin
            r.ready = 1'b1;
            r.value = cdb.value;
        end
        return r;
    endfunction

    always_comb begin
        {src1_ready, src1_tag, src1_value} = read_reg(rs1);
        {src2_ready, src2_tag, src2_value} = read_reg(rs2);
    end

    // Only the newest rename may retire a register
    // A stale tag broadcast finds no match and leaves the value alone
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_pending <= '0;
            for (int i = 0; i < ooo_pkg::num_regs; i++) begin
                reg_value[i] <= '0;
            end
        end else begin
            for (int i = 0; i < ooo_pkg::num_regs; i++) begin
                if (cdb.valid && reg_pending[i] && reg_tag[i] == cdb.tag) begin
                    reg_value[i]   <= cdb.value;
                    reg_pending[i] <= 1'b0;
                end
            end
            // A rename in the same cycle overrides the clear above
            if (write_tag) begin
                reg_pending[rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_tag) begin
            reg_tag[rd] <= new_tag;
        end
    end

endmodule

/* src/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station #(
    parameter int rs_depth = 4,
    parameter int tag_bits = 3
) (
    input  logic                      clk,
    input  logic                      rst,
    dispatch_if.sink                  disp,
    cdb_if.listener                   cdb,
    output logic                      station_full,
    output logic                      issue_valid,
    output ooo_pkg::alu_op_e          issue_op,
    output logic [ooo_pkg::xlen-1:0]  issue_a,
    output logic [ooo_pkg::xlen-1:0]  issue_b,
    output logic [tag_bits-1:0]       issue_tag
);

    localparam int idx_bits = (rs_depth > 1) ? $clog2(rs_depth) : 1;

    ooo_pkg::rs_entry_t            entries [rs_depth];
    logic [rs_depth-1:0]           entry_valid;
    // Running stamp given to each dispatch so older entries compare lower
    logic [ooo_pkg::age_bits-1:0]  age_ctr;

    logic [idx_bits-1:0]           free_idx;
    logic [idx_bits-1:0]           sel_idx;
    ooo_pkg::rs_entry_t            new_entry;

    // Capture a matching broadcast into any operand still waiting on it
    function automatic ooo_pkg::rs_entry_t wake(ooo_pkg::rs_entry_t e);
        ooo_pkg::rs_entry_t w;
        w = e;
        if (cdb.valid && !e.src1_ready && e.src1_tag[tag_bits-1:0] == cdb.tag) begin
            w.src1_ready = 1'b1;
            w.src1_value = cdb.value;
        end
        if (cdb.valid && !e.src2_ready && e.src2_tag[tag_bits-1:0] == cdb.tag) begin
            w.src2_ready = 1'b1;
            w.src2_value = cdb.value;
        end
        return w;
    endfunction

    // Widen the dispatched fields into the station's entry format
    always_comb begin
        new_entry            = '0;
        new_entry.op         = disp.op;
        new_entry.dest_tag   = ooo_pkg::tag_max_t'(disp.dest_tag);
        new_entry.src1_ready = disp.src1_ready;
        new_entry.src1_value = disp.src1_value;
        new_entry.src1_tag   = ooo_pkg::tag_max_t'(disp.src1_tag);
        new_entry.src2_ready = disp.src2_ready;
        new_entry.src2_value = disp.src2_value;
        new_entry.src2_tag   = ooo_pkg::tag_max_t'(disp.src2_tag);
        new_entry.age        = age_ctr;
    end

    // First empty slot takes the next dispatch
    always_comb begin
        free_idx = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                free_idx = idx_bits'(i);
            end
        end
    end

    assign station_full = &entry_valid;

    // Pick the ready entry with the smallest age stamp
    always_comb begin : select_oldest
        logic [ooo_pkg::age_bits-1:0] best_age;
        issue_valid = 1'b0;
        sel_idx     = '0;
        best_age    = '1;
        for (int i = 0; i < rs_depth; i++) begin
            if (entry_valid[i] && entries[i].src1_ready && entries[i].src2_ready &&
                (!issue_valid || entries[i].age < best_age)) begin
                issue_valid = 1'b1;
                sel_idx     = idx_bits'(i);
                best_age    = entries[i].age;
            end
        end
    end

    assign issue_op  = entries[sel_idx].op;
    assign issue_a   = entries[sel_idx].src1_value;
    assign issue_b   = entries[sel_idx].src2_value;
    assign issue_tag = entries[sel_idx].dest_tag[tag_bits-1:0];

    // The dispatch slot is empty now so it never collides with the issued one
    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
            age_ctr     <= '0;
        end else begin
            if (issue_valid) begin
                entry_valid[sel_idx] <= 1'b0;
            end
            if (disp.valid) begin
                entry_valid[free_idx] <= 1'b1;
                age_ctr               <= age_ctr + 1'b1;
            end
        end
    end

    // Stored entries keep listening and a new entry sees this cycle's broadcast
    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_depth; i++) begin
            entries[i] <= wake(entries[i]);
        end
        if (disp.valid) begin
            entries[free_idx] <= wake(new_entry);
        end
    end

    // The source must hold off while the top level shows full
    a_no_dispatch_full: assert property (@(posedge clk) disable iff (rst)
        disp.valid |-> !station_full)
        else $error("dispatch into a full reservation station");

    // A destination tag lives in one entry only, so an issued tag is never on the bus yet
    a_issue_tag_live: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> !(cdb.valid && cdb.tag == issue_tag))
        else $error("issue of tag %0h while the same tag is broadcast", issue_tag);

endmodule

/* src/alu_pipe.sv */
`timescale 1ns/1ps

module alu_pipe #(
    parameter int tag_bits = 3
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_valid,
    input  ooo_pkg::alu_op_e          issue_op,
    input  logic [ooo_pkg::xlen-1:0]  issue_a,
    input  logic [ooo_pkg::xlen-1:0]  issue_b,
    input  logic [tag_bits-1:0]       issue_tag,
    cdb_if.driver                     cdb
);

    // Stage one holds the operands and the decoded adder controls
    logic                      s1_valid;
    ooo_pkg::alu_op_e          s1_op;
    logic [ooo_pkg::xlen-1:0]  s1_a;
    logic [ooo_pkg::xlen-1:0]  s1_b;
    logic [ooo_pkg::xlen-1:0]  s1_addend;
    logic                      s1_carry_in;
    logic [4:0]                s1_shamt;
    logic [tag_bits-1:0]       s1_tag;
    logic [ooo_pkg::xlen-1:0]  result;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            cdb.valid <= 1'b0;
        end else begin
            s1_valid  <= issue_valid;
            cdb.valid <= s1_valid;
        end
    end

    // Subtraction becomes an add of the inverted operand plus one
    always_ff @(posedge clk) begin
        s1_op       <= issue_op;
        s1_a        <= issue_a;
        s1_b        <= issue_b;
        s1_addend   <= (issue_op == ooo_pkg::op_sub) ? ~issue_b : issue_b;
        s1_carry_in <= (issue_op == ooo_pkg::op_sub);
        s1_shamt    <= issue_b[4:0];
        s1_tag      <= issue_tag;
    end

    always_comb begin
        case (s1_op)
            ooo_pkg::op_add,
            ooo_pkg::op_sub: result = s1_a + s1_addend + ooo_pkg::xlen'(s1_carry_in);
            ooo_pkg::op_and: result = s1_a & s1_b;
            ooo_pkg::op_or:  result = s1_a | s1_b;
            ooo_pkg::op_xor: result = s1_a ^ s1_b;
            ooo_pkg::op_sll: result = s1_a << s1_shamt;
            ooo_pkg::op_srl: result = s1_a >> s1_shamt;
            ooo_pkg::op_slt: result = ooo_pkg::xlen'($signed(s1_a) < $signed(s1_b));
            default:         result = '0;
        endcase
    end

    // Stage two drives the common data bus directly from its registers
    always_ff @(posedge clk) begin
        cdb.tag   <= s1_tag;
        cdb.value <= result;
    end

endmodule

/* src/ooo_issue_top.sv */
`timescale 1ns/1ps

module ooo_issue_top #(
    parameter int rs_depth  = 4,
    parameter int tag_count = 8,
    parameter int tag_bits  = 3
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inst_valid,
    input  ooo_pkg::alu_op_e          inst_op,
    input  ooo_pkg::reg_idx_t         inst_rd,
    input  ooo_pkg::reg_idx_t         inst_rs1,
    input  ooo_pkg::reg_idx_t         inst_rs2,
    input  logic                      inst_use_imm,
    input  logic [ooo_pkg::xlen-1:0]  inst_imm,
    output logic                      full,
    output logic [tag_bits-1:0]       dispatch_tag,
    output logic                      result_valid,
    output logic [tag_bits-1:0]       result_tag,
    output logic [ooo_pkg::xlen-1:0]  result_value
);

    dispatch_if #(.tag_bits(tag_bits)) disp_bus ();
    cdb_if #(.tag_bits(tag_bits)) cdb_bus ();

    logic                      none_free;
    logic                      station_full;
    logic [tag_bits-1:0]       alloc_tag;
    logic                      rs2_ready;
    logic [tag_bits-1:0]       rs2_tag;
    logic [ooo_pkg::xlen-1:0]  rs2_value;
    logic                      issue_valid;
    ooo_pkg::alu_op_e          issue_op;
    logic [ooo_pkg::xlen-1:0]  issue_a;
    logic [ooo_pkg::xlen-1:0]  issue_b;
    logic [tag_bits-1:0]       issue_tag;

    tag_allocator #(.tag_count(tag_count), .tag_bits(tag_bits)) tag_alloc_i (
        .clk(clk), .rst(rst), .alloc(inst_valid), .cdb(cdb_bus.listener),
        .alloc_tag(alloc_tag), .none_free(none_free)
    );

    // Operand one goes straight onto the dispatch bus
    register_status #(.tag_bits(tag_bits)) reg_status_i (
        .clk(clk), .rst(rst), .rs1(inst_rs1), .rs2(inst_rs2), .rd(inst_rd),
        .write_tag(inst_valid), .new_tag(alloc_tag), .cdb(cdb_bus.listener),
        .src1_ready(disp_bus.src1_ready), .src1_tag(disp_bus.src1_tag),
        .src1_value(disp_bus.src1_value),
        .src2_ready(rs2_ready), .src2_tag(rs2_tag), .src2_value(rs2_value)
    );

    // An immediate replaces operand two and is ready at once
    assign disp_bus.valid      = inst_valid;
    assign disp_bus.op         = inst_op;
    assign disp_bus.dest_tag   = alloc_tag;
    assign disp_bus.src2_ready = inst_use_imm | rs2_ready;
    assign disp_bus.src2_tag   = rs2_tag;
    assign disp_bus.src2_value = inst_use_imm ? inst_imm : rs2_value;

    reservation_station #(.rs_depth(rs_depth), .tag_bits(tag_bits)) station_i (
        .clk(clk), .rst(rst), .disp(disp_bus.sink), .cdb(cdb_bus.listener),
        .station_full(station_full), .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_a(issue_a), .issue_b(issue_b), .issue_tag(issue_tag)
    );

    alu_pipe #(.tag_bits(tag_bits)) alu_i (
        .clk(clk), .rst(rst), .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_a(issue_a), .issue_b(issue_b), .issue_tag(issue_tag),
        .cdb(cdb_bus.driver)
    );

    // No back-pressure so the source watches full before it strobes
    assign full         = none_free | station_full;
    assign dispatch_tag = alloc_tag;
    assign result_valid = cdb_bus.valid;
    assign result_tag   = cdb_bus.tag;
    assign result_value = cdb_bus.value;

endmodule

/* test/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker #(
    parameter int rs_depth  = 4,
    parameter int tag_count = 8,
    parameter int tag_bits  = 3
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inst_valid,
    input  ooo_pkg::alu_op_e          inst_op,
    input  ooo_pkg::reg_idx_t         inst_rd,
    input  ooo_pkg::reg_idx_t         inst_rs1,
    input  ooo_pkg::reg_idx_t         inst_rs2,
    input  logic                      inst_use_imm,
    input  logic [ooo_pkg::xlen-1:0]  inst_imm,
    input  logic                      full,
    input  logic [tag_bits-1:0]       dispatch_tag,
    input  logic                      result_valid,
    input  logic [tag_bits-1:0]       result_tag,
    input  logic [ooo_pkg::xlen-1:0]  result_value,
    output int                        value_errors,
    output int                        other_errors,
    output int                        outstanding
);

    // In-order architectural model and the expected result per tag
    logic [31:0]          model_regs [8];
    logic [31:0]          expected [tag_count];
    int                   strobe_cycle [tag_count];
    logic [tag_count-1:0] busy;
    int                   cycle;
    int                   disp_total;
    int                   bc_total;
    // Values of the previous cycle, checked once its issues are known
    bit                   prev_valid;
    bit                   prev_full;
    int                   prev_out;
    int                   prev_disp;
    bit                   after_rst;

    function automatic logic [31:0] alu_model(ooo_pkg::alu_op_e op, logic [31:0] a,
                                              logic [31:0] b);
        case (op)
            ooo_pkg::op_add: return a + b;
            ooo_pkg::op_sub: return a - b;
            ooo_pkg::op_and: return a & b;
            ooo_pkg::op_or:  return a | b;
            ooo_pkg::op_xor: return a ^ b;
            ooo_pkg::op_sll: return a << b[4:0];
            ooo_pkg::op_srl: return a >> b[4:0];
            default:         return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic int lowest_free();
        for (int i = 0; i < tag_count; i++) begin
            if (!busy[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    always @(posedge clk) begin : monitor
        logic [31:0] a;
        logic [31:0] b;
        int          out_now;
        int          disp_now;
        int          station;
        bit          exp_full;
        cycle++;
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                model_regs[i] = '0;
            end
            busy       = '0;
            disp_total = 0;
            bc_total   = 0;
            prev_valid = 0;
            after_rst  = 1;
        end else begin
            // Reset state must show an idle DUT in the first cycle after reset
            if (after_rst && (full !== 1'b0 || result_valid !== 1'b0)) begin
                $display("[FAIL] full/result_valid after reset: got %0h/%0h expected 0/0",
                         full, result_valid);
                value_errors++;
            end
            after_rst = 0;
            out_now   = disp_total - bc_total;
            disp_now  = disp_total;
            // The allocator sees this cycle's broadcast tag as still busy
            if (inst_valid && dispatch_tag !== tag_bits'(lowest_free())) begin
                $display("[FAIL] dispatch_tag: got %0h expected %0h", dispatch_tag,
                         lowest_free());
                value_errors++;
            end
            if (result_valid) begin
                if (!busy[result_tag]) begin
                    $display("Broadcast of tag %0d which is not outstanding", result_tag);
                    other_errors++;
                end else begin
                    if (result_value !== expected[result_tag]) begin
                        $display("[FAIL] result_value tag %0h: got %08h expected %08h",
                                 result_tag, result_value, expected[result_tag]);
                        value_errors++;
                    end
                    if (cycle - strobe_cycle[result_tag] < 3) begin
                        $display("Result for tag %0d came %0d cycles after its strobe",
                                 result_tag, cycle - strobe_cycle[result_tag]);
                        other_errors++;
                    end
                    busy[result_tag] = 1'b0;
                    bc_total++;
                end
            end
            if (inst_valid) begin
                a = model_regs[inst_rs1];
                b = inst_use_imm ? inst_imm : model_regs[inst_rs2];
                expected[dispatch_tag]     = alu_model(inst_op, a, b);
                model_regs[inst_rd]        = expected[dispatch_tag];
                strobe_cycle[dispatch_tag] = cycle;
                busy[dispatch_tag]         = 1'b1;
                disp_total++;
            end
            // An entry leaves the station two cycles before its broadcast
            // so the broadcasts up to now settle the previous cycle's occupancy
            if (prev_valid) begin
                station  = prev_disp - bc_total;
                exp_full = (prev_out == tag_count) || (station == rs_depth);
                if (prev_full !== exp_full) begin
                    $display("[FAIL] full at cycle %0d: got %0h expected %0h", cycle - 1,
                             prev_full, exp_full);
                    value_errors++;
                end
            end
            prev_valid = 1;
            prev_full  = full;
            prev_out   = out_now;
            prev_disp  = disp_now;
        end
        outstanding = disp_total - bc_total;
    end

endmodule

/* test/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    localparam int rs_depth    = 4;
    localparam int tag_count   = 8;
    localparam int tag_bits    = 3;
    localparam int stim_count  = 400;
    localparam int stim_limit  = 20000;
    localparam int drain_limit = 2000;

    logic                      clk;
    logic                      rst;
    logic                      inst_valid;
    ooo_pkg::alu_op_e          inst_op;
    ooo_pkg::reg_idx_t         inst_rd;
    ooo_pkg::reg_idx_t         inst_rs1;
    ooo_pkg::reg_idx_t         inst_rs2;
    logic                      inst_use_imm;
    logic [ooo_pkg::xlen-1:0]  inst_imm;
    logic                      full;
    logic [tag_bits-1:0]       dispatch_tag;
    logic                      result_valid;
    logic [tag_bits-1:0]       result_tag;
    logic [ooo_pkg::xlen-1:0]  result_value;
    int                        value_errors;
    int                        other_errors;
    int                        outstanding;
    int                        timeouts;
    int                        seed;

    always #2 clk = ~clk;

    ooo_issue_top #(.rs_depth(rs_depth), .tag_count(tag_count), .tag_bits(tag_bits)) dut_i (
        .clk(clk), .rst(rst), .inst_valid(inst_valid), .inst_op(inst_op),
        .inst_rd(inst_rd), .inst_rs1(inst_rs1), .inst_rs2(inst_rs2),
        .inst_use_imm(inst_use_imm), .inst_imm(inst_imm), .full(full),
        .dispatch_tag(dispatch_tag), .result_valid(result_valid),
        .result_tag(result_tag), .result_value(result_value)
    );

    // Watches the same nets as the DUT ports
    tb_checker #(.rs_depth(rs_depth), .tag_count(tag_count), .tag_bits(tag_bits)) checker_i (
        .clk(clk), .rst(rst), .inst_valid(inst_valid), .inst_op(inst_op),
        .inst_rd(inst_rd), .inst_rs1(inst_rs1), .inst_rs2(inst_rs2),
        .inst_use_imm(inst_use_imm), .inst_imm(inst_imm), .full(full),
        .dispatch_tag(dispatch_tag), .result_valid(result_valid),
        .result_tag(result_tag), .result_value(result_value),
        .value_errors(value_errors), .other_errors(other_errors), .outstanding(outstanding)
    );

    task automatic drive_idle();
        inst_valid   = 1'b0;
        inst_op      = ooo_pkg::op_add;
        inst_rd      = '0;
        inst_rs1     = '0;
        inst_rs2     = '0;
        inst_use_imm = 1'b0;
        inst_imm     = '0;
    endtask

    // Fields come from one random word and the immediate from a second one
    task automatic drive_random_inst();
        logic [31:0] r;
        r = $random(seed);
        inst_valid   = 1'b1;
        inst_op      = ooo_pkg::alu_op_e'(r[2:0]);
        inst_rd      = r[5:3];
        inst_rs1     = r[8:6];
        inst_rs2     = r[11:9];
        inst_use_imm = (r[31:16] % 3) == 0;
        inst_imm     = $random(seed);
    endtask

    initial begin : stimulus
        logic [31:0] r;
        int          sent;
        int          cycles;
        seed     = 82174;
        clk      = 1'b0;
        rst      = 1'b1;
        timeouts = 0;
        sent     = 0;
        cycles   = 0;
        drive_idle();
        repeat (5) @(negedge clk);
        rst = 1'b0;
        // Strobe in about 60% of cycles and never while full is high
        while (sent < stim_count && cycles < stim_limit) begin
            r = $random(seed);
            if (!full && (r % 100) < 60) begin
                drive_random_inst();
                sent++;
            end else begin
                drive_idle();
            end
            cycles++;
            @(negedge clk);
        end
        drive_idle();
        if (sent < stim_count) begin
            $display("Stimulus stalled with only %0d of %0d instructions dispatched",
                     sent, stim_count);
            timeouts++;
        end
        cycles = 0;
        while (outstanding != 0 && cycles < drain_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (outstanding != 0) begin
            $display("Drain timed out with %0d tags never broadcast", outstanding);
            timeouts++;
        end
        // A few quiet cycles catch any extra broadcast
        repeat (5) @(negedge clk);
        $display("errors: %0d value, %0d other, %0d timeout", value_errors, other_errors,
                 timeouts);
        if (value_errors + other_errors + timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* compile.f */
src/ooo_pkg.sv
src/ooo_ifs.sv
src/tag_allocator.sv
src/register_status.sv
src/reservation_station.sv
src/alu_pipe.sv
src/ooo_issue_top.sv
test/tb_checker.sv
test/tb_top.sv
